// File: proc_config.svh
`ifndef PROC_CONFIG_SVH
`define PROC_CONFIG_SVH

// Data path and address width, memories are word addressed
`define PROC_XLEN 32

// Register index width, 32 architectural registers
`define PROC_REG_BITS 5

// Width of the opcode and ALU-operation fields
`define PROC_OP_BITS 5

// Return-address register written by jal
`define PROC_LINK_REG 5'd31

// First fetch address after reset
`define PROC_RESET_PC 32'h0000_0000

`endif

// File: isa_pkg.sv
`include "proc_config.svh"

package isa_pkg;

    // Primary opcodes, insn[31:27]
    typedef enum logic [`PROC_OP_BITS-1:0] {
        op_rtype = 5'b00000,
        op_j     = 5'b00001,
        op_bne   = 5'b00010,
        op_jal   = 5'b00011,
        op_jr    = 5'b00100,
        op_addi  = 5'b00101,
        op_blt   = 5'b00110,
        op_sw    = 5'b00111,
        op_lw    = 5'b01000
    } opcode_e;

    // R-type function field, insn[6:2]
    typedef enum logic [`PROC_OP_BITS-1:0] {
        alu_add = 5'd0,
        alu_sub = 5'd1,
        alu_and = 5'd2,
        alu_or  = 5'd3,
        alu_sll = 5'd4,
        alu_sra = 5'd5
    } alu_op_e;

    // Immediate is bits 16:0, jump target is bits 26:0
    // All-zero word is add r0, r0, r0 and serves as the bubble
    typedef struct packed {
        opcode_e                   opcode;
        logic [`PROC_REG_BITS-1:0] rd;
        logic [`PROC_REG_BITS-1:0] rs;
        logic [`PROC_REG_BITS-1:0] rt;
        logic [4:0]                shamt;
        alu_op_e                   alu_op;
        logic [1:0]                spare;
    } insn_t;

    // Destination register, jal links through r31
    function automatic logic [`PROC_REG_BITS-1:0] dest_reg(insn_t insn);
        return (insn.opcode == op_jal) ? `PROC_LINK_REG : insn.rd;
    endfunction

    // True when the instruction commits a register write
    function automatic logic writes_reg(insn_t insn);
        logic kind;
        kind = insn.opcode inside {op_rtype, op_addi, op_lw, op_jal};
        return kind && (dest_reg(insn) != '0);
    endfunction

    // Second source index, branches, jr and sw name it in rd
    function automatic logic [`PROC_REG_BITS-1:0] src_b_reg(insn_t insn);
        if (insn.opcode inside {op_bne, op_blt, op_jr, op_sw}) begin
            return insn.rd;
        end
        return insn.rt;
    endfunction

endpackage

// File: pipe_pkg.sv
`include "proc_config.svh"

package pipe_pkg;
    import isa_pkg::*;

    // Fetch to decode
    typedef struct packed {
        logic [`PROC_XLEN-1:0] pc;
        insn_t                 insn;
    } if_id_t;

    // Decode to execute, operands as read from the register file
    typedef struct packed {
        logic [`PROC_XLEN-1:0] pc;
        logic [`PROC_XLEN-1:0] a;
        logic [`PROC_XLEN-1:0] b;
        insn_t                 insn;
    } id_ex_t;

    // Execute to memory, b is the store data
    typedef struct packed {
        logic [`PROC_XLEN-1:0] result;
        logic [`PROC_XLEN-1:0] b;
        insn_t                 insn;
    } ex_mem_t;

    // Memory to writeback
    typedef struct packed {
        logic [`PROC_XLEN-1:0] result;
        logic [`PROC_XLEN-1:0] load_data;
        insn_t                 insn;
    } mem_wb_t;

    // Register-file write port
    typedef struct packed {
        logic                      en;
        logic [`PROC_REG_BITS-1:0] idx;
        logic [`PROC_XLEN-1:0]     data;
    } rf_write_t;

    // Data-memory request
    typedef struct packed {
        logic [`PROC_XLEN-1:0] addr;
        logic [`PROC_XLEN-1:0] data;
        logic                  wren;
    } dmem_req_t;

endpackage

// File: proc_alu.sv
`include "proc_config.svh"

module proc_alu
    import isa_pkg::*;
(
    input  logic [`PROC_XLEN-1:0] a,
    input  logic [`PROC_XLEN-1:0] b,
    input  alu_op_e               op,
    input  logic [4:0]            shamt,
    output logic [`PROC_XLEN-1:0] result,
    output logic                  not_equal,
    output logic                  less_than
);

    logic [`PROC_XLEN-1:0] diff;
    logic                  ovf;

    // Flags always come from a - b, whatever op is selected
    assign diff = a - b;

    // Signed overflow of the subtraction
    assign ovf = (a[`PROC_XLEN-1] ^ b[`PROC_XLEN-1]) & (diff[`PROC_XLEN-1] ^ a[`PROC_XLEN-1]);

    assign not_equal = |diff;
    // Sign of the true difference
    assign less_than = diff[`PROC_XLEN-1] ^ ovf;

    always_comb begin
        case (op)
            alu_add: result = a + b;
            alu_sub: result = diff;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_sll: result = a << shamt;
            // Arithmetic shift keeps the sign
            alu_sra: result = $signed(a) >>> shamt;
            default: result = a + b;
        endcase
    end

endmodule

// File: proc_fetch.sv
`include "proc_config.svh"

module proc_fetch
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  load_stall,
    input  logic                  redirect,
    input  logic [`PROC_XLEN-1:0] redirect_pc,
    output logic [`PROC_XLEN-1:0] pc,
    input  insn_t                 insn,
    output if_id_t                if_id
);

    // Program counter, redirect has priority over the load stall
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `PROC_RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!load_stall) begin
            pc <= pc + 32'd1;
        end
    end

    // Fetch/decode register
    // Wrong-path fetch turns into a bubble on redirect
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            if_id <= '0;
        end else if (redirect) begin
            if_id <= '0;
        end else if (!load_stall) begin
            if_id <= '{pc: pc, insn: insn};
        end
    end

    // Stalled fetch must present the same address next cycle
    a_pc_hold: assert property (@(posedge clock) disable iff (!arst_n)
        load_stall && !redirect |=> pc == $past(pc));

endmodule

// File: proc_decode.sv
`include "proc_config.svh"

module proc_decode
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                      clock,
    input  logic                      arst_n,
    input  if_id_t                    if_id,
    input  logic                      redirect,
    output logic [`PROC_REG_BITS-1:0] read_a,
    output logic [`PROC_REG_BITS-1:0] read_b,
    input  logic [`PROC_XLEN-1:0]     data_a,
    input  logic [`PROC_XLEN-1:0]     data_b,
    output logic                      load_stall,
    output id_ex_t                    id_ex
);

    logic                      uses_a;
    logic                      uses_b;
    logic                      ex_is_load;
    logic [`PROC_REG_BITS-1:0] ex_dest;

    // Port a always addresses rs
    assign read_a = if_id.insn.rs;
    assign read_b = src_b_reg(if_id.insn);

    // Which ports carry a real dependency
    // sw store data is left out, it gets bypassed in the memory stage
    assign uses_a = if_id.insn.opcode inside {op_rtype, op_addi, op_lw, op_sw, op_bne, op_blt};
    assign uses_b = if_id.insn.opcode inside {op_rtype, op_bne, op_blt, op_jr};

    // Load sitting in execute
    assign ex_is_load = (id_ex.insn.opcode == op_lw) && (id_ex.insn.rd != '0);
    assign ex_dest    = id_ex.insn.rd;

    assign load_stall = ex_is_load &&
                        ((uses_a && (read_a == ex_dest)) || (uses_b && (read_b == ex_dest)));

    // Decode/execute register
    // Bubble goes in behind a load, or in place of a wrong-path instruction
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            id_ex <= '0;
        end else if (redirect || load_stall) begin
            id_ex <= '0;
        end else begin
            id_ex <= '{pc: if_id.pc, a: data_a, b: data_b, insn: if_id.insn};
        end
    end

    // Stall only behind a lw and lasts exactly one cycle
    a_stall_one: assert property (@(posedge clock) disable iff (!arst_n)
        load_stall |-> (id_ex.insn.opcode == op_lw) ##1 !load_stall);

endmodule

// File: proc_execute.sv
`include "proc_config.svh"

module proc_execute
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                  clock,
    input  logic                  arst_n,
    input  id_ex_t                id_ex,
    input  ex_mem_t               mem_fwd,
    input  rf_write_t             wb_fwd,
    output logic                  redirect,
    output logic [`PROC_XLEN-1:0] redirect_pc,
    output ex_mem_t               ex_mem
);

    logic [`PROC_XLEN-1:0] insn_bits;
    logic [`PROC_XLEN-1:0] true_a;
    logic [`PROC_XLEN-1:0] true_b;
    logic [`PROC_XLEN-1:0] imm_ext;
    logic [`PROC_XLEN-1:0] jump_target;
    logic [`PROC_XLEN-1:0] pc_next;
    logic [`PROC_XLEN-1:0] alu_b;
    logic [`PROC_XLEN-1:0] alu_result;
    alu_op_e               alu_sel;
    logic                  use_imm;
    logic                  not_equal;
    logic                  less_than;

    // Operand bypass, memory stage first, then writeback, then register file
    function automatic logic [`PROC_XLEN-1:0] bypass(
        input logic [`PROC_REG_BITS-1:0] idx,
        input logic [`PROC_XLEN-1:0]     rf_val,
        input ex_mem_t                   mem_src,
        input rf_write_t                 wb_src
    );
        logic mem_hit;
        logic wb_hit;
        // A load in memory has no data yet, the load-use stall covers it
        mem_hit = writes_reg(mem_src.insn) && (mem_src.insn.opcode != op_lw) &&
                  (dest_reg(mem_src.insn) == idx);
        wb_hit  = wb_src.en && (wb_src.idx == idx);
        if (idx == '0) begin
            return rf_val;
        end else if (mem_hit) begin
            return mem_src.result;
        end else if (wb_hit) begin
            return wb_src.data;
        end
        return rf_val;
    endfunction

    assign insn_bits = id_ex.insn;
    assign true_a    = bypass(id_ex.insn.rs, id_ex.a, mem_fwd, wb_fwd);
    assign true_b    = bypass(src_b_reg(id_ex.insn), id_ex.b, mem_fwd, wb_fwd);

    // 17-bit immediate and 27-bit target, both sign extended
    assign imm_ext     = {{(`PROC_XLEN-17){insn_bits[16]}}, insn_bits[16:0]};
    assign jump_target = {{(`PROC_XLEN-27){insn_bits[26]}}, insn_bits[26:0]};
    assign pc_next     = id_ex.pc + 32'd1;

    // addi, lw and sw add the immediate to rs
    assign use_imm = id_ex.insn.opcode inside {op_addi, op_lw, op_sw};
    assign alu_b   = use_imm ? imm_ext : true_b;

    always_comb begin
        case (id_ex.insn.opcode)
            op_rtype:       alu_sel = id_ex.insn.alu_op;
            op_bne, op_blt: alu_sel = alu_sub;
            default:        alu_sel = alu_add;
        endcase
    end

    proc_alu i_alu (
        .a         (true_a),
        .b         (alu_b),
        .op        (alu_sel),
        .shamt     (id_ex.insn.shamt),
        .result    (alu_result),
        .not_equal (not_equal),
        .less_than (less_than)
    );

    // Branch resolution, a holds rs and b holds rd
    // blt takes when rd < rs, i.e. rs above rd
    always_comb begin
        redirect    = 1'b0;
        redirect_pc = pc_next + imm_ext;
        case (id_ex.insn.opcode)
            op_bne: redirect = not_equal;
            op_blt: redirect = not_equal && !less_than;
            op_j, op_jal: begin
                redirect    = 1'b1;
                redirect_pc = jump_target;
            end
            op_jr: begin
                redirect    = 1'b1;
                redirect_pc = true_b;
            end
            default: ;
        endcase
    end

    // Execute/memory register, jal carries its return address
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem.result <= (id_ex.insn.opcode == op_jal) ? pc_next : alu_result;
            ex_mem.b      <= true_b;
            ex_mem.insn   <= id_ex.insn;
        end
    end

endmodule

// File: proc_mem_wb.sv
`include "proc_config.svh"

module proc_mem_wb
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                  clock,
    input  logic                  arst_n,
    input  ex_mem_t               ex_mem,
    input  logic [`PROC_XLEN-1:0] q_dmem,
    output dmem_req_t             dmem_req,
    output rf_write_t             rf_write
);

    mem_wb_t mem_wb;
    logic    is_store;
    logic    store_fwd;

    // Address always comes from the ALU result
    assign is_store      = ex_mem.insn.opcode == op_sw;
    assign dmem_req.addr = ex_mem.result;
    assign dmem_req.wren = is_store;

    // A write still in writeback overrides the store data
    // This also covers a lw right ahead of the sw
    assign store_fwd     = is_store && rf_write.en && (rf_write.idx == ex_mem.insn.rd);
    assign dmem_req.data = store_fwd ? rf_write.data : ex_mem.b;

    // Memory/writeback register
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb <= '{result: ex_mem.result, load_data: q_dmem, insn: ex_mem.insn};
        end
    end

    // Writeback
    assign rf_write.en   = writes_reg(mem_wb.insn);
    assign rf_write.idx  = dest_reg(mem_wb.insn);
    assign rf_write.data = (mem_wb.insn.opcode == op_lw) ? mem_wb.load_data : mem_wb.result;

    a_no_r0: assert property (@(posedge clock) disable iff (!arst_n)
        rf_write.en |-> rf_write.idx != '0);

endmodule

// File: processor.sv
`include "proc_config.svh"

module processor
    import pipe_pkg::*;
(
    input  logic                      clock,
    input  logic                      arst_n,
    output logic [`PROC_XLEN-1:0]     address_imem,
    input  isa_pkg::insn_t            q_imem,
    output dmem_req_t                 dmem_req,
    input  logic [`PROC_XLEN-1:0]     q_dmem,
    output logic [`PROC_REG_BITS-1:0] ctrl_read_reg_a,
    output logic [`PROC_REG_BITS-1:0] ctrl_read_reg_b,
    input  logic [`PROC_XLEN-1:0]     data_read_reg_a,
    input  logic [`PROC_XLEN-1:0]     data_read_reg_b,
    output rf_write_t                 rf_write
);

    if_id_t                if_id;
    id_ex_t                id_ex;
    ex_mem_t               ex_mem;
    logic                  load_stall;
    logic                  redirect;
    logic [`PROC_XLEN-1:0] redirect_pc;

    proc_fetch i_fetch (
        .clock       (clock),
        .arst_n      (arst_n),
        .load_stall  (load_stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc          (address_imem),
        .insn        (q_imem),
        .if_id       (if_id)
    );

    // Register-file reads happen in decode
    proc_decode i_decode (
        .clock      (clock),
        .arst_n     (arst_n),
        .if_id      (if_id),
        .redirect   (redirect),
        .read_a     (ctrl_read_reg_a),
        .read_b     (ctrl_read_reg_b),
        .data_a     (data_read_reg_a),
        .data_b     (data_read_reg_b),
        .load_stall (load_stall),
        .id_ex      (id_ex)
    );

    // Memory-stage bypass source is the execute/memory register itself
    proc_execute i_execute (
        .clock       (clock),
        .arst_n      (arst_n),
        .id_ex       (id_ex),
        .mem_fwd     (ex_mem),
        .wb_fwd      (rf_write),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .ex_mem      (ex_mem)
    );

    proc_mem_wb i_mem_wb (
        .clock    (clock),
        .arst_n   (arst_n),
        .ex_mem   (ex_mem),
        .q_dmem   (q_dmem),
        .dmem_req (dmem_req),
        .rf_write (rf_write)
    );

endmodule

// File: tb_mem_model.sv
`include "proc_config.svh"

module tb_mem_model
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                      clock,
    input  logic [`PROC_XLEN-1:0]     address_imem,
    output insn_t                     q_imem,
    input  dmem_req_t                 dmem_req,
    output logic [`PROC_XLEN-1:0]     q_dmem,
    input  logic [`PROC_REG_BITS-1:0] read_a,
    input  logic [`PROC_REG_BITS-1:0] read_b,
    output logic [`PROC_XLEN-1:0]     data_a,
    output logic [`PROC_XLEN-1:0]     data_b,
    input  rf_write_t                 rf_write
);
    timeunit 1ns;
    timeprecision 100ps;

    // Contents are loaded by the testbench before reset
    insn_t                 rom  [0:31];
    logic [`PROC_XLEN-1:0] dram [0:255];
    logic [`PROC_XLEN-1:0] regs [0:31];

    // Instruction ROM and data RAM answer in the same cycle
    assign q_imem = rom[address_imem[4:0]];
    assign q_dmem = dram[dmem_req.addr[7:0]];

    // Register file is write-through on a matching index
    assign data_a = (rf_write.en && rf_write.idx == read_a) ? rf_write.data : regs[read_a];
    assign data_b = (rf_write.en && rf_write.idx == read_b) ? rf_write.data : regs[read_b];

    always @(posedge clock) begin
        if (dmem_req.wren) begin
            dram[dmem_req.addr[7:0]] <= dmem_req.data;
        end
        // r0 stays zero
        if (rf_write.en && rf_write.idx != 5'd0) begin
            regs[rf_write.idx] <= rf_write.data;
        end
    end

endmodule

// File: tb_processor.sv
`include "proc_config.svh"

module tb_processor
    import isa_pkg::*;
    import pipe_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic                      clock;
    logic                      arst_n;
    logic [`PROC_XLEN-1:0]     address_imem;
    insn_t                     q_imem;
    dmem_req_t                 dmem_req;
    logic [`PROC_XLEN-1:0]     q_dmem;
    logic [`PROC_REG_BITS-1:0] read_a;
    logic [`PROC_REG_BITS-1:0] read_b;
    logic [`PROC_XLEN-1:0]     data_a;
    logic [`PROC_XLEN-1:0]     data_b;
    rf_write_t                 rf_write;

    // Reference model state and expected write lists
    insn_t       prog       [0:31];
    logic [31:0] model_regs [0:31];
    logic [31:0] model_mem  [0:255];
    logic [4:0]  exp_rf_idx [0:63];
    logic [31:0] exp_rf_data[0:63];
    logic [31:0] exp_mem_addr[0:15];
    logic [31:0] exp_mem_data[0:15];
    int          rf_count;
    int          mem_count;
    int          n_insn;
    int          limit;
    int          rf_seen;
    int          mem_seen;
    int          cycles;
    logic [31:0] lcg_state;

    processor i_dut (
        .clock           (clock),
        .arst_n          (arst_n),
        .address_imem    (address_imem),
        .q_imem          (q_imem),
        .dmem_req        (dmem_req),
        .q_dmem          (q_dmem),
        .ctrl_read_reg_a (read_a),
        .ctrl_read_reg_b (read_b),
        .data_read_reg_a (data_a),
        .data_read_reg_b (data_b),
        .rf_write        (rf_write)
    );

    tb_mem_model i_mem (
        .clock        (clock),
        .address_imem (address_imem),
        .q_imem       (q_imem),
        .dmem_req     (dmem_req),
        .q_dmem       (q_dmem),
        .read_a       (read_a),
        .read_b       (read_b),
        .data_a       (data_a),
        .data_b       (data_b),
        .rf_write     (rf_write)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Data RAM fill depends on every address bit
    function automatic logic [31:0] fill_word(logic [7:0] k);
        return {k, ~k, k ^ 8'h3c, 8'hc5};
    endfunction

    function automatic insn_t r_insn(alu_op_e op, logic [4:0] rd, logic [4:0] rs,
                                     logic [4:0] rt, logic [4:0] sh);
        return {op_rtype, rd, rs, rt, sh, op, 2'b00};
    endfunction

    function automatic insn_t i_insn(opcode_e op, logic [4:0] rd, logic [4:0] rs,
                                     logic [16:0] imm);
        return {op, rd, rs, imm};
    endfunction

    function automatic insn_t j_insn(opcode_e op, logic [26:0] target);
        return {op, target};
    endfunction

    // ISA semantics of the R-type operations
    function automatic logic [31:0] alu_ref(alu_op_e op, logic [31:0] a, logic [31:0] b,
                                            logic [4:0] sh);
        case (op)
            alu_sub: return a - b;
            alu_and: return a & b;
            alu_or:  return a | b;
            alu_sll: return a << sh;
            alu_sra: return $signed(a) >>> sh;
            default: return a + b;
        endcase
    endfunction

    task automatic record_reg(logic [4:0] idx, logic [31:0] val);
        if (idx != 5'd0) begin
            model_regs[idx] = val;
            exp_rf_idx[rf_count] = idx;
            exp_rf_data[rf_count] = val;
            rf_count++;
        end
    endtask

    // Dependent ALU chain, store/load pairs, branches, then jal, jr, j and a self-jump
    task automatic build_program();
        prog[0]  = i_insn(op_addi, 5'd1, 5'd1, 17'(next_random()));
        prog[1]  = r_insn(alu_add, 5'd2, 5'd1, 5'd3, 5'd0);
        prog[2]  = r_insn(alu_sub, 5'd4, 5'd2, 5'd1, 5'd0);
        prog[3]  = r_insn(alu_and, 5'd5, 5'd4, 5'd2, 5'd0);
        prog[4]  = r_insn(alu_or,  5'd6, 5'd5, 5'd4, 5'd0);
        prog[5]  = r_insn(alu_sll, 5'd7, 5'd6, 5'd0, 5'(next_random()));
        prog[6]  = r_insn(alu_sra, 5'd8, 5'd7, 5'd0, 5'(next_random()));
        prog[7]  = i_insn(op_addi, 5'd9, 5'd0, 17'(32'd32 + (next_random() & 32'h7f)));
        prog[8]  = i_insn(op_sw,   5'd8, 5'd9, 17'd0);
        prog[9]  = i_insn(op_lw,   5'd10, 5'd9, 17'd0);
        prog[10] = r_insn(alu_add, 5'd11, 5'd10, 5'd1, 5'd0);
        prog[11] = i_insn(op_lw,   5'd12, 5'd9, 17'd0);
        prog[12] = i_insn(op_sw,   5'd12, 5'd9, 17'd1);
        prog[13] = i_insn(op_lw,   5'd13, 5'd9, 17'd1);
        prog[14] = i_insn(op_bne,  5'd13, 5'd12, 17'd2);
        prog[15] = i_insn(op_bne,  5'd1, 5'd2, 17'd2);
        prog[16] = i_insn(op_addi, 5'd14, 5'd0, 17'd1);
        prog[17] = i_insn(op_addi, 5'd15, 5'd0, 17'd2);
        // Positive r9 against r0 makes this blt fall through on unequal operands
        prog[18] = i_insn(op_blt,  5'd9, 5'd0, 17'd5);
        // Negative constant so that the following blt is taken
        prog[19] = i_insn(op_addi, 5'd16, 5'd0, 17'h1ff00 | 17'(next_random() & 32'hff));
        prog[20] = i_insn(op_blt,  5'd16, 5'd0, 17'd2);
        prog[21] = i_insn(op_addi, 5'd14, 5'd0, 17'd3);
        prog[22] = i_insn(op_addi, 5'd15, 5'd0, 17'd4);
        prog[23] = j_insn(op_jal,  27'd28);
        prog[24] = j_insn(op_j,    27'd27);
        prog[25] = i_insn(op_addi, 5'd14, 5'd0, 17'd5);
        prog[26] = i_insn(op_addi, 5'd15, 5'd0, 17'd6);
        prog[27] = j_insn(op_j,    27'd27);
        prog[28] = i_insn(op_addi, 5'd18, 5'd31, 17'd1);
        prog[29] = i_insn(op_jr,   5'd31, 5'd0, 17'd0);
        prog[30] = i_insn(op_addi, 5'd14, 5'd0, 17'd7);
        prog[31] = i_insn(op_addi, 5'd15, 5'd0, 17'd8);
    endtask

    // In-order ISA model that stops at the self-jump
    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] pc_next;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] tgt;
        insn_t       ins;
        logic        done;
        pc = `PROC_RESET_PC;
        done = 1'b0;
        while (!done && n_insn < 200) begin
            ins = prog[pc[4:0]];
            n_insn++;
            a = model_regs[ins.rs];
            b = model_regs[ins.rd];
            imm = {{15{ins[16]}}, ins[16:0]};
            tgt = {{5{ins[26]}}, ins[26:0]};
            pc_next = pc + 32'd1;
            case (ins.opcode)
                op_rtype: begin
                    record_reg(ins.rd,
                               alu_ref(ins.alu_op, a, model_regs[ins.rt], ins.shamt));
                end
                op_addi:  record_reg(ins.rd, a + imm);
                op_lw:    record_reg(ins.rd, model_mem[8'(a + imm)]);
                op_sw: begin
                    model_mem[8'(a + imm)] = b;
                    exp_mem_addr[mem_count] = a + imm;
                    exp_mem_data[mem_count] = b;
                    mem_count++;
                end
                op_bne: begin
                    if (b != a) begin
                        pc_next = pc + 32'd1 + imm;
                    end
                end
                op_blt: begin
                    if ($signed(b) < $signed(a)) begin
                        pc_next = pc + 32'd1 + imm;
                    end
                end
                op_j: begin
                    done = (tgt == pc);
                    pc_next = tgt;
                end
                op_jal: begin
                    record_reg(`PROC_LINK_REG, pc + 32'd1);
                    pc_next = tgt;
                end
                op_jr:   pc_next = b;
                default: ;
            endcase
            pc = pc_next;
        end
    endtask

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            cycles <= 0;
            rf_seen <= 0;
            mem_seen <= 0;
        end else begin
            cycles <= cycles + 1;
            if (rf_write.en) begin
                rf_seen <= rf_seen + 1;
            end
            if (dmem_req.wren) begin
                mem_seen <= mem_seen + 1;
            end
        end
    end

    // Nothing reaches memory or the register file before the pipeline fills
    a_quiet_start: assert property (@(posedge clock) disable iff (!arst_n)
        cycles < 3 |-> !dmem_req.wren && !rf_write.en)
        else stop_on_error("A write strobe was active before any instruction reached memory");

    a_no_r0: assert property (@(posedge clock) disable iff (!arst_n)
        rf_write.en |-> rf_write.idx != 5'd0)
        else stop_on_error("The processor wrote register 0");

    a_rf_extra: assert property (@(posedge clock) disable iff (!arst_n)
        rf_write.en |-> rf_seen < rf_count)
        else stop_on_error("The processor made more register writes than the program has");

    a_rf_value: assert property (@(posedge clock) disable iff (!arst_n)
        rf_write.en && rf_seen < rf_count |->
            rf_write.idx == exp_rf_idx[rf_seen] && rf_write.data == exp_rf_data[rf_seen])
        else stop_on_error($sformatf(
            "Error at %0t: register write expected r%0d = %h, got r%0d = %h",
            $time, exp_rf_idx[$sampled(rf_seen)], exp_rf_data[$sampled(rf_seen)],
            $sampled(rf_write.idx), $sampled(rf_write.data)));

    a_mem_extra: assert property (@(posedge clock) disable iff (!arst_n)
        dmem_req.wren |-> mem_seen < mem_count)
        else stop_on_error("The processor made more memory writes than the program has");

    a_mem_value: assert property (@(posedge clock) disable iff (!arst_n)
        dmem_req.wren && mem_seen < mem_count |->
            dmem_req.addr == exp_mem_addr[mem_seen] && dmem_req.data == exp_mem_data[mem_seen])
        else stop_on_error($sformatf(
            "Error at %0t: memory write expected [%h] = %h, got [%h] = %h",
            $time, exp_mem_addr[$sampled(mem_seen)], exp_mem_data[$sampled(mem_seen)],
            $sampled(dmem_req.addr), $sampled(dmem_req.data)));

    initial begin
        arst_n = 1'b0;
        lcg_state = 32'd38108;
        rf_count = 0;
        mem_count = 0;
        n_insn = 0;
        model_regs[0] = 32'd0;
        for (int k = 1; k < 32; k++) begin
            model_regs[k] = next_random();
        end
        // r3 odd keeps r2 apart from r1 for the bne
        model_regs[3] = model_regs[3] | 32'd1;
        for (int k = 0; k < 256; k++) begin
            model_mem[k] = fill_word(8'(k));
            i_mem.dram[k] = fill_word(8'(k));
        end
        build_program();
        for (int k = 0; k < 32; k++) begin
            i_mem.rom[k] = prog[k];
            i_mem.regs[k] = model_regs[k];
        end
        run_model();
        limit = 4 * n_insn + 50;
        repeat (2) @(posedge clock);
        #1 arst_n = 1'b1;
        while (!(rf_seen == rf_count && mem_seen == mem_count) && cycles < limit) begin
            @(posedge clock);
            #1;
        end
        if (rf_seen == rf_count && mem_seen == mem_count) begin
            // A few more cycles so that a stray write would still be caught
            repeat (4) @(posedge clock);
            $display("All tests passed");
            $finish;
        end else begin
            $display("Timeout: the program did not finish within %0d cycles", limit);
            $display("Some tests failed");
            $fatal(1);
        end
    end

endmodule

// File: files.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
proc_alu.sv
proc_fetch.sv
proc_decode.sv
proc_execute.sv
proc_mem_wb.sv
processor.sv
tb_mem_model.sv
tb_processor.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_processor -f files.f -o tb_processor
./obj_dir/tb_processor > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
if ! grep -q "All tests passed" sim.log; then
    exit 1
fi
exit 0
